// File: btb_unit.f
design/btb_pkg.sv
design/branch_decode.sv
design/btb_store.sv
design/counter_update.sv
design/predict_result.sv
design/btb_top.sv
verif/btb_assertions.sv
verif/btb_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module btb_tb -f btb_unit.f -o btb_sim
	./obj_dir/btb_sim 2>&1 | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: verif/btb_tb.sv
`timescale 1ns/1ps

module btb_tb;

    localparam int directed_accesses = 100;
    localparam int random_ops        = 200;
    localparam int planned_accesses  = directed_accesses + random_ops * 3;  // 3 per op
    localparam int max_cycles        = planned_accesses * 20 + 8;
    localparam int ack_limit         = 16;

    localparam btb_pkg::tag_t   tag_pool [3]   = '{26'h0000010, 26'h0000777, 26'h3ABCDEF};
    localparam btb_pkg::index_t index_pool [4] = '{4'd0, 4'd5, 4'd10, 4'd15};

    logic           clk = 1'b0;
    logic           reset;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    logic [4:0]     wb_adr;
    btb_pkg::word_t wb_dat_w;
    btb_pkg::word_t wb_dat_r;
    logic           wb_ack;

    // reference copy of the table
    logic           ref_valid [16];
    btb_pkg::tag_t  ref_tag [16];
    btb_pkg::word_t ref_target [16];
    btb_pkg::ctr_t  ref_ctr [16];

    // reads waiting for the compare process
    string          name_q [$];
    bit             kind_q [$];  // 1 for a predict status
    btb_pkg::word_t exp_q [$];
    btb_pkg::word_t act_q [$];
    int             checks_queued = 0;
    int             checks_done = 0;
    int             cycle_count = 0;

    btb_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    function automatic logic model_hit(btb_pkg::word_t pc);
        return ref_valid[pc[5:2]] && (ref_tag[pc[5:2]] == pc[31:6]);
    endfunction

    function automatic void model_resolve(btb_pkg::word_t pc, btb_pkg::word_t target,
                                          logic taken);
        btb_pkg::index_t idx;
        idx = pc[5:2];
        if (model_hit(pc)) begin
            if (taken) begin
                ref_target[idx] = target;
                if (ref_ctr[idx] != 2'd3) begin
                    ref_ctr[idx] = ref_ctr[idx] + 2'd1;
                end
            end else if (ref_ctr[idx] != 2'd0) begin
                ref_ctr[idx] = ref_ctr[idx] - 2'd1;
            end
        end else if (taken) begin
            ref_valid[idx]  = 1'b1;  // allocate, evicting whatever sat here
            ref_tag[idx]    = pc[31:6];
            ref_target[idx] = target;
            ref_ctr[idx]    = 2'd2;
        end
    endfunction

    // {taken, hit}
    function automatic logic [1:0] model_status(btb_pkg::word_t pc);
        logic hit;
        hit = model_hit(pc);
        return {hit && (ref_ctr[pc[5:2]] >= 2'd2), hit};
    endfunction

    function automatic btb_pkg::word_t model_next_pc(btb_pkg::word_t pc);
        logic [1:0] status;
        status = model_status(pc);
        return status[1] ? ref_target[pc[5:2]] : pc + 32'd4;
    endfunction

    task automatic check_word(input string name, input btb_pkg::word_t expected,
                              input btb_pkg::word_t actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_predict(input string name, input logic [1:0] expected,
                                 input logic [1:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %b actual %b", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic queue_check(input string name, input bit is_status,
                               input btb_pkg::word_t expected, input btb_pkg::word_t actual);
        name_q.push_back(name);
        kind_q.push_back(is_status);
        exp_q.push_back(expected);
        act_q.push_back(actual);
        checks_queued++;
    endtask

    // one classic cycle, released on the falling edge that sees ack
    task automatic bus_access(input logic we, input logic [4:0] adr,
                              input btb_pkg::word_t wdata, output btb_pkg::word_t rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ack_limit) begin
                $display("no ack within %0d cycles for offset %h", ack_limit, adr);
                $display("ERRORS FOUND");
                $fatal(1);
            end
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [4:0] adr, input btb_pkg::word_t data);
        btb_pkg::word_t unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [4:0] adr, output btb_pkg::word_t data);
        bus_access(1'b0, adr, '0, data);
    endtask

    task automatic resolve(input btb_pkg::word_t pc, input btb_pkg::word_t target,
                           input logic taken);
        bus_write(btb_pkg::reg_res_pc, pc);
        bus_write(btb_pkg::reg_res_target, target);
        bus_write(btb_pkg::reg_res_cmd, {31'd0, taken});
        model_resolve(pc, target, taken);
    endtask

    task automatic lookup(input string name, input btb_pkg::word_t pc);
        btb_pkg::word_t status;
        btb_pkg::word_t next_pc;
        bus_write(btb_pkg::reg_lookup_pc, pc);
        bus_read(btb_pkg::reg_predict, status);
        bus_read(btb_pkg::reg_next_pc, next_pc);
        queue_check({name, " status"}, 1'b1, {30'd0, model_status(pc)}, status);
        queue_check({name, " next_pc"}, 1'b0, model_next_pc(pc), next_pc);
    endtask

    // compare process, drains the queue between falling edges
    initial begin
        string          name;
        bit             is_status;
        btb_pkg::word_t expected;
        btb_pkg::word_t actual;
        forever begin
            @(posedge clk);
            while (act_q.size() > 0) begin
                name      = name_q.pop_front();
                is_status = kind_q.pop_front();
                expected  = exp_q.pop_front();
                actual    = act_q.pop_front();
                if (is_status) begin
                    check_predict(name, expected[1:0], actual[1:0]);
                    check_word({name, " upper bits"}, '0, {actual[31:2], 2'b00});
                end else begin
                    check_word(name, expected, actual);
                end
                checks_done++;
            end
        end
    end

    initial begin
        btb_pkg::word_t pc_a;
        btb_pkg::word_t pc_b;
        btb_pkg::word_t pc;
        btb_pkg::word_t rdata;
        int             t;
        int             i;
        void'($urandom(99508));
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int n = 0; n < 16; n++) begin
            ref_valid[n]  = 1'b0;
            ref_tag[n]    = '0;
            ref_target[n] = '0;
            ref_ctr[n]    = 2'd0;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;

        // empty table after reset
        lookup("reset low pc", 32'h0000_1000);
        lookup("reset high pc", 32'h8000_003C);
        lookup("reset random pc", $urandom);

        pc_a = 32'h0000_1048;  // index 2
        resolve(pc_a, 32'h0000_2000, 1'b1);
        lookup("allocate", pc_a);

        resolve(pc_a, 32'h0000_2000, 1'b1);  // strong taken
        lookup("strong taken", pc_a);
        resolve(pc_a, 32'h0000_2000, 1'b0);
        lookup("first not taken", pc_a);
        resolve(pc_a, 32'h0000_2000, 1'b0);
        lookup("second not taken", pc_a);
        repeat (2) begin
            resolve(pc_a, 32'h0000_2000, 1'b0);
            lookup("saturate low", pc_a);
        end
        repeat (4) begin
            resolve(pc_a, 32'h0000_3000, 1'b1);
            lookup("saturate high", pc_a);
        end

        // same index, other tag
        pc_b = pc_a + 32'h0000_0400;
        lookup("alias miss", pc_b);
        resolve(pc_b, 32'h0000_4000, 1'b0);
        lookup("not taken miss", pc_b);
        lookup("first pc kept", pc_a);
        resolve(pc_b, 32'h0000_4000, 1'b1);
        lookup("evicted pc", pc_a);
        lookup("evicting pc", pc_b);

        for (int op = 0; op < random_ops; op++) begin
            t  = int'($urandom % 3);
            i  = int'($urandom % 4);
            pc = {tag_pool[t], index_pool[i], 2'($urandom % 4)};
            if ($urandom % 2 == 0) begin
                resolve(pc, $urandom, ($urandom % 3) != 0);
            end else begin
                lookup("random lookup", pc);
            end
        end

        bus_write(btb_pkg::reg_lookup_pc, 32'hDEAD_BEEC);
        bus_read(btb_pkg::reg_lookup_pc, rdata);
        queue_check("lookup_pc readback", 1'b0, 32'hDEAD_BEEC, rdata);
        bus_write(5'h18, 32'h1234_5678);  // unmapped write is dropped
        bus_read(btb_pkg::reg_lookup_pc, rdata);
        queue_check("lookup_pc after unmapped write", 1'b0, 32'hDEAD_BEEC, rdata);
        bus_read(5'h18, rdata);
        queue_check("unmapped 0x18", 1'b0, '0, rdata);
        bus_read(5'h1C, rdata);
        queue_check("unmapped 0x1c", 1'b0, '0, rdata);
        bus_read(btb_pkg::reg_res_target, rdata);
        queue_check("write only res_target", 1'b0, '0, rdata);

        while (checks_done != checks_queued) begin
            @(posedge clk);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: verif/btb_assertions.sv
`timescale 1ns/1ps

module btb_assertions (
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic wr_en
);

    // the slave acks for exactly one cycle
    property ack_single_cycle;
        @(posedge clk) disable iff (reset)
            wb_ack |=> !wb_ack;
    endproperty

    // an ack answers a request seen at the previous edge
    property ack_after_request;
        @(posedge clk) disable iff (reset)
            $rose(wb_ack) |-> $past(wb_cyc && wb_stb);
    endproperty

    // the store is written only while a command write is acked
    property write_in_ack_cycle;
        @(posedge clk) disable iff (reset)
            wr_en |-> wb_ack;
    endproperty

    a_ack_single_cycle: assert property (ack_single_cycle)
        else $error("wb_ack stayed high for two cycles");
    a_ack_after_request: assert property (ack_after_request)
        else $error("wb_ack rose without cyc and stb");
    a_write_in_ack_cycle: assert property (write_in_ack_cycle)
        else $error("store write outside an ack cycle");

endmodule

bind btb_top btb_assertions u_assertions (
    .clk    (clk),
    .reset  (reset),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .wr_en  (wr_en)
);

// File: design/btb_top.sv
`timescale 1ns/1ps

module btb_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [4:0]       wb_adr,
    input  btb_pkg::word_t   wb_dat_w,
    output btb_pkg::word_t   wb_dat_r,
    output logic             wb_ack
);

    btb_pkg::word_t  res_pc;
    btb_pkg::word_t  res_target;
    btb_pkg::word_t  lookup_pc;
    btb_pkg::word_t  rd_data;
    logic            res_taken;
    logic            res_valid;
    logic [4:0]      rd_sel;

    btb_pkg::index_t rd1_index;
    btb_pkg::index_t rd2_index;
    btb_pkg::tag_t   rd1_tag;
    btb_pkg::tag_t   rd2_tag;
    btb_pkg::word_t  rd1_target;
    btb_pkg::word_t  rd2_target;
    btb_pkg::ctr_t   rd1_ctr;
    btb_pkg::ctr_t   rd2_ctr;
    logic            hit1;
    logic            hit2;

    logic            wr_en;
    btb_pkg::index_t wr_index;
    btb_pkg::tag_t   wr_tag;
    btb_pkg::word_t  wr_target;
    btb_pkg::ctr_t   wr_ctr;

    branch_decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .rd_data    (rd_data),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .res_pc     (res_pc),
        .res_target (res_target),
        .lookup_pc  (lookup_pc),
        .res_taken  (res_taken),
        .res_valid  (res_valid),
        .rd_sel     (rd_sel)
    );

    btb_store u_store (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_index   (wr_index),
        .wr_tag     (wr_tag),
        .wr_target  (wr_target),
        .wr_ctr     (wr_ctr),
        .rd1_index  (rd1_index),
        .rd2_index  (rd2_index),
        .rd1_tag    (rd1_tag),
        .rd2_tag    (rd2_tag),
        .rd1_target (rd1_target),
        .rd2_target (rd2_target),
        .rd1_ctr    (rd1_ctr),
        .rd2_ctr    (rd2_ctr),
        .hit1       (hit1),
        .hit2       (hit2)
    );

    counter_update u_execute (
        .res_valid  (res_valid),
        .res_taken  (res_taken),
        .res_pc     (res_pc),
        .res_target (res_target),
        .hit2       (hit2),
        .rd2_target (rd2_target),
        .rd2_ctr    (rd2_ctr),
        .rd2_index  (rd2_index),
        .rd2_tag    (rd2_tag),
        .wr_en      (wr_en),
        .wr_index   (wr_index),
        .wr_tag     (wr_tag),
        .wr_target  (wr_target),
        .wr_ctr     (wr_ctr)
    );

    predict_result u_result (
        .lookup_pc  (lookup_pc),
        .rd_sel     (rd_sel),
        .hit1       (hit1),
        .rd1_target (rd1_target),
        .rd1_ctr    (rd1_ctr),
        .rd1_index  (rd1_index),
        .rd1_tag    (rd1_tag),
        .rd_data    (rd_data)
    );

endmodule

// File: design/predict_result.sv
`timescale 1ns/1ps

module predict_result (
    input  btb_pkg::word_t     lookup_pc,
    input  logic [4:0]         rd_sel,
    input  logic               hit1,
    input  btb_pkg::word_t     rd1_target,
    input  btb_pkg::ctr_t      rd1_ctr,
    output btb_pkg::index_t    rd1_index,
    output btb_pkg::tag_t      rd1_tag,
    output btb_pkg::word_t     rd_data
);

    logic           taken;
    btb_pkg::word_t next_pc;

    assign rd1_index = lookup_pc[btb_pkg::index_w+1:2];
    assign rd1_tag   = lookup_pc[btb_pkg::addr_w-1:btb_pkg::addr_w-btb_pkg::tag_w];

    // weak or strong taken on a hit
    assign taken   = hit1 && (rd1_ctr >= btb_pkg::ctr_weak_t);
    assign next_pc = taken ? rd1_target : lookup_pc + 32'd4;  // fall through

    always_comb begin
        case (rd_sel)
            btb_pkg::reg_predict:   rd_data = {30'd0, taken, hit1};
            btb_pkg::reg_next_pc:   rd_data = next_pc;
            btb_pkg::reg_lookup_pc: rd_data = lookup_pc;
            default:                rd_data = '0;  // write only and unmapped read 0
        endcase
    end

endmodule

// File: design/counter_update.sv
`timescale 1ns/1ps

module counter_update (
    input  logic               res_valid,
    input  logic               res_taken,
    input  btb_pkg::word_t     res_pc,
    input  btb_pkg::word_t     res_target,
    input  logic               hit2,
    input  btb_pkg::word_t     rd2_target,
    input  btb_pkg::ctr_t      rd2_ctr,
    output btb_pkg::index_t    rd2_index,
    output btb_pkg::tag_t      rd2_tag,
    output logic               wr_en,
    output btb_pkg::index_t    wr_index,
    output btb_pkg::tag_t      wr_tag,
    output btb_pkg::word_t     wr_target,
    output btb_pkg::ctr_t      wr_ctr
);

    // pc bits 5:2 index the line, bits 31:6 form the tag
    assign rd2_index = res_pc[btb_pkg::index_w+1:2];
    assign rd2_tag   = res_pc[btb_pkg::addr_w-1:btb_pkg::addr_w-btb_pkg::tag_w];

    assign wr_index = rd2_index;
    assign wr_tag   = rd2_tag;

    always_comb begin
        wr_en     = 1'b0;
        wr_target = rd2_target;
        wr_ctr    = rd2_ctr;
        if (res_valid) begin
            if (hit2) begin
                wr_en = 1'b1;
                if (res_taken) begin
                    wr_target = res_target;      // newest target wins
                    if (rd2_ctr != btb_pkg::ctr_strong_t) begin
                        wr_ctr = rd2_ctr + 2'd1;
                    end
                end else if (rd2_ctr != btb_pkg::ctr_strong_nt) begin
                    wr_ctr = rd2_ctr - 2'd1;
                end
            end else if (res_taken) begin
                // allocate, may evict another tag on this index
                wr_en     = 1'b1;
                wr_target = res_target;
                wr_ctr    = btb_pkg::ctr_weak_t;
            end
            // not-taken miss leaves the table alone
        end
    end

endmodule

// File: design/btb_store.sv
`timescale 1ns/1ps

module btb_store (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_en,
    input  btb_pkg::index_t    wr_index,
    input  btb_pkg::tag_t      wr_tag,
    input  btb_pkg::word_t     wr_target,
    input  btb_pkg::ctr_t      wr_ctr,
    input  btb_pkg::index_t    rd1_index,
    input  btb_pkg::index_t    rd2_index,
    input  btb_pkg::tag_t      rd1_tag,
    input  btb_pkg::tag_t      rd2_tag,
    output btb_pkg::word_t     rd1_target,
    output btb_pkg::word_t     rd2_target,
    output btb_pkg::ctr_t      rd1_ctr,
    output btb_pkg::ctr_t      rd2_ctr,
    output logic               hit1,
    output logic               hit2
);

    logic [btb_pkg::lines-1:0] valid;
    btb_pkg::tag_t             tag_mem    [btb_pkg::lines];
    btb_pkg::word_t            target_mem [btb_pkg::lines];
    btb_pkg::ctr_t             ctr_mem    [btb_pkg::lines];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= '0;               // empty table after reset
        end else if (wr_en) begin
            valid[wr_index] <= 1'b1;
        end
    end

    // line payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]    <= wr_tag;
            target_mem[wr_index] <= wr_target;
            ctr_mem[wr_index]    <= wr_ctr;
        end
    end

    // port 1, lookup side
    assign hit1       = valid[rd1_index] && (tag_mem[rd1_index] == rd1_tag);
    assign rd1_target = hit1 ? target_mem[rd1_index] : '0;
    assign rd1_ctr    = hit1 ? ctr_mem[rd1_index]    : btb_pkg::ctr_strong_nt;

    // port 2, resolve side
    assign hit2       = valid[rd2_index] && (tag_mem[rd2_index] == rd2_tag);
    assign rd2_target = hit2 ? target_mem[rd2_index] : '0;
    assign rd2_ctr    = hit2 ? ctr_mem[rd2_index]    : btb_pkg::ctr_strong_nt;

endmodule

// File: design/branch_decode.sv
`timescale 1ns/1ps

module branch_decode (
    input  logic             clk,
    input  logic             reset,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [4:0]       wb_adr,
    input  btb_pkg::word_t   wb_dat_w,
    input  btb_pkg::word_t   rd_data,
    output btb_pkg::word_t   wb_dat_r,
    output logic             wb_ack,
    output btb_pkg::word_t   res_pc,
    output btb_pkg::word_t   res_target,
    output btb_pkg::word_t   lookup_pc,
    output logic             res_taken,
    output logic             res_valid,
    output logic [4:0]       rd_sel
);

    logic accept;
    logic cmd_write;

    // one access at a time, ack low in the accept cycle
    assign accept    = wb_cyc && wb_stb && !wb_ack;
    assign cmd_write = accept && wb_we && (wb_adr == btb_pkg::reg_res_cmd);

    // offset of the access in progress, held by the master until ack
    assign rd_sel = wb_adr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            wb_ack    <= accept;     // single-cycle ack, never back to back
            res_valid <= cmd_write;  // resolve strobe lines up with ack
        end
    end

    // register file, loaded at the edge that raises ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            res_pc     <= '0;
            res_target <= '0;
            res_taken  <= 1'b0;
            lookup_pc  <= '0;
        end else if (accept && wb_we) begin
            case (wb_adr)
                btb_pkg::reg_res_pc:     res_pc     <= wb_dat_w;
                btb_pkg::reg_res_target: res_target <= wb_dat_w;
                btb_pkg::reg_res_cmd:    res_taken  <= wb_dat_w[0];
                btb_pkg::reg_lookup_pc:  lookup_pc  <= wb_dat_w;
                default: ;               // unmapped or read only, dropped
            endcase
        end
    end

    // read data registered together with ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_dat_r <= '0;
        end else if (accept) begin
            wb_dat_r <= wb_we ? '0 : rd_data;
        end
    end

endmodule

// File: design/btb_pkg.sv
package btb_pkg;

    localparam int addr_w  = 32;
    localparam int lines   = 16;
    localparam int index_w = $clog2(lines);         // 4 for 16 lines
    localparam int tag_w   = addr_w - index_w - 2;  // bits 1:0 are word alignment

    typedef logic [addr_w-1:0]  word_t;
    typedef logic [index_w-1:0] index_t;
    typedef logic [tag_w-1:0]   tag_t;
    typedef logic [1:0]         ctr_t;

    // 2-bit saturating prediction counter
    localparam ctr_t ctr_strong_nt = 2'd0;
    localparam ctr_t ctr_weak_nt   = 2'd1;
    localparam ctr_t ctr_weak_t    = 2'd2;
    localparam ctr_t ctr_strong_t  = 2'd3;

    // register byte offsets on the 5-bit bus address
    localparam logic [4:0] reg_res_pc     = 5'h00;  // write only
    localparam logic [4:0] reg_res_target = 5'h04;  // write only
    localparam logic [4:0] reg_res_cmd    = 5'h08;  // bit 0 taken, write starts resolve
    localparam logic [4:0] reg_lookup_pc  = 5'h0C;
    localparam logic [4:0] reg_predict    = 5'h10;  // bit 0 hit, bit 1 taken
    localparam logic [4:0] reg_next_pc    = 5'h14;

endpackage
